// ==== plane_precompute.f ====
+incdir+include
logic/plane_pkg.sv
logic/plane_step_control.sv
logic/plane_gradient.sv
logic/plane_param_combine.sv
logic/plane_precompute.sv
tb/plane_precompute_tb.sv

// ==== tb/plane_precompute_tb.sv ====
// expected values follow the plane rules for 8-bit pels; inputs change 2 ns after each rising edge
`timescale 1ns/1ps
`include "plane_consts.svh"

module plane_precompute_tb;

	localparam int NUM_ENTRIES    = 14;
	localparam int TIMEOUT_CYCLES = 16 + 16 * NUM_ENTRIES + 200;
	localparam int DONE_WAIT_MAX  = 32;
	localparam int HOLD_CYCLES    = 4;

	logic                   clk;
	logic                   reset_n;
	logic                   start;
	logic                   is_luma;
	plane_pkg::pel_line_t   top_line;
	plane_pkg::pel_line_t   left_line;
	plane_pkg::pel_t        corner;
	logic                   busy;
	plane_pkg::plane_a_t    plane_a;
	plane_pkg::plane_bc_t   plane_b;
	plane_pkg::plane_bc_t   plane_c;
	plane_pkg::plane_seed_t seed;
	logic                   done;

	// stimulus and expected table
	string                  t_name [NUM_ENTRIES];
	logic                   t_luma [NUM_ENTRIES];
	plane_pkg::pel_line_t   t_top [NUM_ENTRIES];
	plane_pkg::pel_line_t   t_left [NUM_ENTRIES];
	plane_pkg::pel_t        t_corner [NUM_ENTRIES];
	logic                   t_restart [NUM_ENTRIES];
	plane_pkg::plane_a_t    t_a [NUM_ENTRIES];
	plane_pkg::plane_bc_t   t_b [NUM_ENTRIES];
	plane_pkg::plane_bc_t   t_c [NUM_ENTRIES];
	plane_pkg::plane_seed_t t_seed [NUM_ENTRIES];
	int                     t_latency [NUM_ENTRIES];

	int cycle_count = 0;
	int error_count = 0;
	int check_count = 0;

	plane_precompute dut
	(
		.clk       (clk),
		.reset_n   (reset_n),
		.start     (start),
		.is_luma   (is_luma),
		.top_line  (top_line),
		.left_line (left_line),
		.corner    (corner),
		.busy      (busy),
		.plane_a   (plane_a),
		.plane_b   (plane_b),
		.plane_c   (plane_c),
		.seed      (seed),
		.done      (done)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("run stopped after %0d cycles without finishing the tests", cycle_count);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	// index -1 selects the corner
	function automatic int pel_at(input plane_pkg::pel_line_t line, input plane_pkg::pel_t crn,
		input int i);
		if (i < 0)
			return int'(crn);
		return int'(line[i*`PLANE_PEL_W +: `PLANE_PEL_W]);
	endfunction

	function automatic int gradient_sum(input plane_pkg::pel_line_t line,
		input plane_pkg::pel_t crn, input logic luma);
		int k_half;
		int sum;
		k_half = luma ? `PLANE_LUMA_STEPS : `PLANE_CHROMA_STEPS;
		sum = 0;
		for (int k = 0; k < k_half; k++)
			sum += (k + 1) * (pel_at(line, crn, k_half + k) - pel_at(line, crn, k_half - 2 - k));
		return sum;
	endfunction

	// arithmetic shift on a signed int
	function automatic int bc_rule(input int g, input logic luma);
		int mul;
		mul = luma ? `PLANE_LUMA_MUL : `PLANE_CHROMA_MUL;
		return (mul * g + `PLANE_ROUND) >>> `PLANE_SHIFT;
	endfunction

	function automatic plane_pkg::pel_line_t random_line();
		plane_pkg::pel_line_t line;
		for (int w = 0; w < 4; w++)
			line[w*32 +: 32] = $urandom;
		return line;
	endfunction

	function automatic plane_pkg::pel_line_t ramp_line(input int first, input int inc);
		plane_pkg::pel_line_t line;
		for (int i = 0; i < `PLANE_LUMA_N; i++)
			line[i*`PLANE_PEL_W +: `PLANE_PEL_W] = 8'(first + inc * i);
		return line;
	endfunction

	task automatic set_entry(input int idx, input string name, input logic luma,
		input plane_pkg::pel_line_t top, input plane_pkg::pel_line_t left,
		input plane_pkg::pel_t crn, input logic restart);
		int k_half;
		int n;
		int a_i;
		int b_i;
		int c_i;
		k_half = luma ? `PLANE_LUMA_STEPS : `PLANE_CHROMA_STEPS;
		n      = luma ? `PLANE_LUMA_N : `PLANE_CHROMA_N;
		a_i    = (1 << `PLANE_A_SHIFT) * (pel_at(left, crn, n - 1) + pel_at(top, crn, n - 1));
		b_i    = bc_rule(gradient_sum(top, crn, luma), luma);
		c_i    = bc_rule(gradient_sum(left, crn, luma), luma);
		t_name[idx]    = name;
		t_luma[idx]    = luma;
		t_top[idx]     = top;
		t_left[idx]    = left;
		t_corner[idx]  = crn;
		t_restart[idx] = restart;
		t_a[idx]       = plane_pkg::plane_a_t'(a_i);
		t_b[idx]       = plane_pkg::plane_bc_t'(b_i);
		t_c[idx]       = plane_pkg::plane_bc_t'(c_i);
		// 16-bit wrap of the seed
		t_seed[idx]    = plane_pkg::plane_seed_t'(a_i - (k_half - 1) * b_i - k_half * c_i);
		t_latency[idx] = k_half + 2;
	endtask

	task automatic build_table();
		for (int i = 0; i < 4; i++)
			set_entry(i, $sformatf("luma_random_%0d", i), 1'b1, random_line(), random_line(),
				8'($urandom), 1'b0);
		set_entry(4, "luma_flat", 1'b1, {16{8'd128}}, {16{8'd77}}, 8'd128, 1'b0);
		set_entry(5, "luma_ramp", 1'b1, ramp_line(10, 9), ramp_line(200, -7), 8'd3, 1'b0);
		// upper pels of the chroma lines are random too
		for (int i = 0; i < 4; i++)
			set_entry(6 + i, $sformatf("chroma_random_%0d", i), 1'b0, random_line(),
				random_line(), 8'($urandom), 1'b0);
		set_entry(10, "luma_top_rise", 1'b1, ramp_line(0, 17), ramp_line(255, -17), 8'd0, 1'b0);
		set_entry(11, "luma_top_fall", 1'b1, ramp_line(255, -17), ramp_line(0, 17), 8'd255, 1'b0);
		set_entry(12, "chroma_extreme", 1'b0, ramp_line(0, 36), ramp_line(252, -36), 8'd255, 1'b0);
		set_entry(13, "luma_restart", 1'b1, random_line(), random_line(), 8'($urandom), 1'b1);
	endtask

	// --------------------------------------------------
	// checking
	// --------------------------------------------------
	task automatic check_value(input string name, input logic signed [31:0] expected,
		input logic signed [31:0] actual);
		check_count++;
		if (expected !== actual)
		begin
			error_count++;
			$display("** Error %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic check_results(input int idx, input string tag);
		check_value({t_name[idx], tag, " a"}, t_a[idx], plane_a);
		check_value({t_name[idx], tag, " b"}, t_b[idx], plane_b);
		check_value({t_name[idx], tag, " c"}, t_c[idx], plane_c);
		check_value({t_name[idx], tag, " seed"}, t_seed[idx], seed);
	endtask

	task automatic run_entry(input int idx);
		int latency;
		logic seen;
		is_luma   = t_luma[idx];
		top_line  = t_top[idx];
		left_line = t_left[idx];
		corner    = t_corner[idx];
		start     = 1'b1;
		@(posedge clk);
		#2;
		latency = 0;
		seen    = 1'b0;
		while (!seen && latency < DONE_WAIT_MAX)
		begin
			// extra start while busy carries the other mode on is_luma
			start   = t_restart[idx] && latency == 2;
			is_luma = start ? !t_luma[idx] : t_luma[idx];
			@(posedge clk);
			#2;
			latency++;
			seen = done;
			if (!seen)
				check_value({t_name[idx], " busy"}, 1, busy);
		end
		start   = 1'b0;
		is_luma = t_luma[idx];
		if (!seen)
		begin
			error_count++;
			$display("%s: done never came within %0d cycles", t_name[idx], DONE_WAIT_MAX);
		end
		else
		begin
			check_value({t_name[idx], " latency"}, t_latency[idx], latency);
			check_value({t_name[idx], " busy at done"}, 0, busy);
			check_results(idx, "");
		end
		// results hold and no second done follows
		repeat (HOLD_CYCLES)
		begin
			@(posedge clk);
			#2;
			check_value({t_name[idx], " done after"}, 0, done);
			check_results(idx, " hold");
		end
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial
	begin
		void'($urandom(32'h23edab8b));
		reset_n   = 1'b0;
		start     = 1'b0;
		is_luma   = 1'b0;
		top_line  = '0;
		left_line = '0;
		corner    = '0;
		build_table();
		repeat (16) @(posedge clk);
		#2;
		reset_n = 1'b1;
		check_value("reset busy", 0, busy);
		check_value("reset done", 0, done);
		check_value("reset a", 0, plane_a);
		check_value("reset b", 0, plane_b);
		check_value("reset c", 0, plane_c);
		check_value("reset seed", 0, seed);
		for (int i = 0; i < NUM_ENTRIES; i++)
			run_entry(i);
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== logic/plane_precompute.sv ====
// one start pulse per block; hold lines and corner until done, which comes K+2 cycles later
`timescale 1ns/1ps

module plane_precompute
(
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   start,
	input  logic                   is_luma,
	input  plane_pkg::pel_line_t   top_line,
	input  plane_pkg::pel_line_t   left_line,
	input  plane_pkg::pel_t        corner,
	output logic                   busy,
	output plane_pkg::plane_a_t    plane_a,
	output plane_pkg::plane_bc_t   plane_b,
	output plane_pkg::plane_bc_t   plane_c,
	output plane_pkg::plane_seed_t seed,
	output logic                   done
);

	logic                 mode_luma;
	logic                 clear;
	plane_pkg::step_idx_t step;
	logic                 step_valid;
	logic                 steps_done;
	plane_pkg::grad_t     grad_h;
	plane_pkg::grad_t     grad_v;

	// --------------------------------------------------
	// step sequencing
	// --------------------------------------------------
	plane_step_control u_control
	(
		.clk        (clk),
		.reset_n    (reset_n),
		.start      (start),
		.is_luma    (is_luma),
		.busy       (busy),
		.mode_luma  (mode_luma),
		.clear      (clear),
		.step       (step),
		.step_valid (step_valid),
		.steps_done (steps_done)
	);

	// --------------------------------------------------
	// H from the top row, V from the left column
	// --------------------------------------------------
	plane_gradient grad_h_unit
	(
		.clk        (clk),
		.reset_n    (reset_n),
		.line       (top_line),
		.corner     (corner),
		.mode_luma  (mode_luma),
		.clear      (clear),
		.step       (step),
		.step_valid (step_valid),
		.grad       (grad_h)
	);

	plane_gradient grad_v_unit
	(
		.clk        (clk),
		.reset_n    (reset_n),
		.line       (left_line),
		.corner     (corner),
		.mode_luma  (mode_luma),
		.clear      (clear),
		.step       (step),
		.step_valid (step_valid),
		.grad       (grad_v)
	);

	// a, b, c and seed
	plane_param_combine u_combine
	(
		.clk        (clk),
		.reset_n    (reset_n),
		.top_line   (top_line),
		.left_line  (left_line),
		.grad_h     (grad_h),
		.grad_v     (grad_v),
		.mode_luma  (mode_luma),
		.steps_done (steps_done),
		.plane_a    (plane_a),
		.plane_b    (plane_b),
		.plane_c    (plane_c),
		.seed       (seed),
		.done       (done)
	);

endmodule

// ==== logic/plane_param_combine.sv ====
// lines must be held until done; mode_luma must stay constant from steps_done through done
`timescale 1ns/1ps
`include "plane_consts.svh"

module plane_param_combine
(
	input  logic                   clk,
	input  logic                   reset_n,
	input  plane_pkg::pel_line_t   top_line,
	input  plane_pkg::pel_line_t   left_line,
	input  plane_pkg::grad_t       grad_h,
	input  plane_pkg::grad_t       grad_v,
	input  logic                   mode_luma,
	input  logic                   steps_done,
	output plane_pkg::plane_a_t    plane_a,
	output plane_pkg::plane_bc_t   plane_b,
	output plane_pkg::plane_bc_t   plane_c,
	output plane_pkg::plane_seed_t seed,
	output logic                   done
);

	localparam int LUMA_K_SHIFT   = $clog2(`PLANE_LUMA_STEPS);
	localparam int CHROMA_K_SHIFT = $clog2(`PLANE_CHROMA_STEPS);

	logic [3:0]             far_idx;
	plane_pkg::pel_t        far_top;
	plane_pkg::pel_t        far_left;
	logic [8:0]             pel_sum;
	plane_pkg::plane_a_t    a_next;
	logic signed [15:0]     a_ext;
	logic signed [15:0]     b_ext;
	logic signed [15:0]     c_ext;
	logic signed [15:0]     kb;
	logic signed [15:0]     kc;
	plane_pkg::plane_seed_t seed_next;
	logic                   seed_step;

	// (mul * g + 32) >>> 6 with mul = 5 luma, 34 chroma
	function automatic plane_pkg::plane_bc_t scale_round(
		input plane_pkg::grad_t g,
		input logic             luma
	);
		logic signed [20:0] g_ext;
		logic signed [20:0] scaled;
		logic signed [20:0] rounded;
		g_ext = {{6{g[14]}}, g};
		if (luma)
			scaled = g_ext * `PLANE_LUMA_MUL;
		else
			scaled = g_ext * `PLANE_CHROMA_MUL;
		rounded = scaled + `PLANE_ROUND;
		scale_round = plane_pkg::plane_bc_t'(rounded >>> `PLANE_SHIFT);
	endfunction

	// --------------------------------------------------
	// a from the far-end pels, index N-1
	// --------------------------------------------------
	assign far_idx = mode_luma ?
		4'(`PLANE_LUMA_N - 1) :
		4'(`PLANE_CHROMA_N - 1);

	assign far_top  = top_line[far_idx*`PLANE_PEL_W +: `PLANE_PEL_W];
	assign far_left = left_line[far_idx*`PLANE_PEL_W +: `PLANE_PEL_W];
	assign pel_sum  = {1'b0, far_top} + {1'b0, far_left};
	assign a_next   = plane_pkg::plane_a_t'(pel_sum) << `PLANE_A_SHIFT;

	// --------------------------------------------------
	// seed = a - (K-1)*b - K*c
	// --------------------------------------------------
	assign a_ext = $signed({2'b00, plane_a});
	assign b_ext = {{4{plane_b[11]}}, plane_b};
	assign c_ext = {{4{plane_c[11]}}, plane_c};

	// K is a power of two in both modes
	assign kb = mode_luma ? (b_ext <<< LUMA_K_SHIFT) : (b_ext <<< CHROMA_K_SHIFT);
	assign kc = mode_luma ? (c_ext <<< LUMA_K_SHIFT) : (c_ext <<< CHROMA_K_SHIFT);

	assign seed_next = a_ext - (kb - b_ext) - kc;

	// --------------------------------------------------
	// result registers
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			plane_a   <= '0;
			plane_b   <= '0;
			plane_c   <= '0;
			seed      <= '0;
			seed_step <= 1'b0;
			done      <= 1'b0;
		end
		else
		begin
			seed_step <= steps_done;
			done      <= seed_step;
			// first combine cycle
			if (steps_done)
			begin
				plane_a <= a_next;
				plane_b <= scale_round(grad_h, mode_luma);
				plane_c <= scale_round(grad_v, mode_luma);
			end
			// second combine cycle uses the registered a, b, c
			if (seed_step)
				seed <= seed_next;
		end
	end

endmodule

// ==== logic/plane_gradient.sv ====
// line and corner must stay stable while step_valid is high; one step per cycle, no stall
`timescale 1ns/1ps
`include "plane_consts.svh"

module plane_gradient
(
	input  logic                 clk,
	input  logic                 reset_n,
	input  plane_pkg::pel_line_t line,
	input  plane_pkg::pel_t      corner,
	input  logic                 mode_luma,
	input  logic                 clear,
	input  plane_pkg::step_idx_t step,
	input  logic                 step_valid,
	output plane_pkg::grad_t     grad
);

	logic [3:0]        half;
	logic [3:0]        step_ext;
	logic [3:0]        upper_idx;
	logic [3:0]        lower_idx;
	logic              last_step;
	plane_pkg::pel_t   upper_pel;
	plane_pkg::pel_t   lower_pel;
	logic signed [8:0] diff;
	logic signed [11:0] diff_ext;
	logic [3:0]        weight;
	logic signed [11:0] term;

	// --------------------------------------------------
	// pel selection for step k
	// --------------------------------------------------
	// K for the active mode
	assign half = mode_luma ?
		4'(`PLANE_LUMA_STEPS) :
		4'(`PLANE_CHROMA_STEPS);

	assign step_ext  = {1'b0, step};
	assign upper_idx = half + step_ext;
	assign lower_idx = half - 4'd2 - step_ext;

	// the lower pel of the last step is index -1, the corner
	assign last_step = (step_ext == half - 4'd1);

	assign upper_pel = line[upper_idx*`PLANE_PEL_W +: `PLANE_PEL_W];
	assign lower_pel = last_step ?
		corner :
		line[lower_idx*`PLANE_PEL_W +: `PLANE_PEL_W];

	// --------------------------------------------------
	// weighted difference (k+1) * (upper - lower)
	// --------------------------------------------------
	assign diff     = $signed({1'b0, upper_pel}) - $signed({1'b0, lower_pel});
	assign diff_ext = {{3{diff[8]}}, diff};

	// weight runs 1..8
	assign weight = step_ext + 4'd1;

	// shift and add per weight bit
	always_comb
	begin
		term = '0;
		if (weight[0])
			term = term + diff_ext;
		if (weight[1])
			term = term + (diff_ext <<< 1);
		if (weight[2])
			term = term + (diff_ext <<< 2);
		if (weight[3])
			term = term + (diff_ext <<< 3);
	end

	// --------------------------------------------------
	// accumulator
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			grad <= '0;
		end
		else if (clear)
		begin
			grad <= '0;
		end
		else if (step_valid)
		begin
			// sum of 8 weighted terms fits 15 bits signed
			grad <= grad + {{3{term[11]}}, term};
		end
	end

endmodule

// ==== logic/plane_step_control.sv ====
// start is dropped while busy; mode is sampled with start and held until the next start
`timescale 1ns/1ps
`include "plane_consts.svh"

module plane_step_control
(
	input  logic                 clk,
	input  logic                 reset_n,
	input  logic                 start,
	input  logic                 is_luma,
	output logic                 busy,
	output logic                 mode_luma,
	output logic                 clear,
	output plane_pkg::step_idx_t step,
	output logic                 step_valid,
	output logic                 steps_done
);

	plane_pkg::step_state_e state;
	plane_pkg::step_idx_t   last_step;
	logic                   finish_tail;

	// final step index for the latched mode
	assign last_step = mode_luma ?
		plane_pkg::step_idx_t'(`PLANE_LUMA_STEPS - 1) :
		plane_pkg::step_idx_t'(`PLANE_CHROMA_STEPS - 1);

	assign busy       = (state != plane_pkg::IDLE);
	assign step_valid = (state == plane_pkg::STEP);

	// accumulators are zeroed on the edge that accepts start
	assign clear = start && (state == plane_pkg::IDLE);

	// --------------------------------------------------
	// IDLE -> STEP (K cycles) -> FINISH (2 cycles)
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			state       <= plane_pkg::IDLE;
			mode_luma   <= 1'b0;
			step        <= '0;
			finish_tail <= 1'b0;
			steps_done  <= 1'b0;
		end
		else
		begin
			steps_done <= 1'b0;
			case (state)
				plane_pkg::IDLE:
				begin
					if (start)
					begin
						mode_luma <= is_luma;
						step      <= '0;
						state     <= plane_pkg::STEP;
					end
				end
				plane_pkg::STEP:
				begin
					if (step == last_step)
					begin
						steps_done  <= 1'b1;
						finish_tail <= 1'b0;
						state       <= plane_pkg::FINISH;
					end
					else
					begin
						step <= step + plane_pkg::step_idx_t'(1);
					end
				end
				plane_pkg::FINISH:
				begin
					// first cycle registers a, b, c; second registers the seed
					if (finish_tail)
						state <= plane_pkg::IDLE;
					else
						finish_tail <= 1'b1;
				end
				default:
				begin
					state <= plane_pkg::IDLE;
				end
			endcase
		end
	end

endmodule

// ==== logic/plane_pkg.sv ====
// shared types for plane precompute; a chroma line occupies the low 8 pels of pel_line_t
`include "plane_consts.svh"

package plane_pkg;

	// --------------------------------------------------
	// pel data
	// --------------------------------------------------
	typedef logic [`PLANE_PEL_W-1:0] pel_t;

	// pel i sits at bits 8i+7 down to 8i
	typedef logic [`PLANE_LUMA_N*`PLANE_PEL_W-1:0] pel_line_t;

	// --------------------------------------------------
	// plane results
	// --------------------------------------------------
	// weighted difference sum, H or V
	typedef logic signed [`PLANE_GRAD_W-1:0] grad_t;

	typedef logic signed [`PLANE_BC_W-1:0] plane_bc_t;
	typedef logic [`PLANE_A_W-1:0] plane_a_t;
	typedef logic signed [`PLANE_SEED_W-1:0] plane_seed_t;

	// gradient step index k
	typedef logic [`PLANE_STEP_W-1:0] step_idx_t;

	// controller states
	typedef enum logic [1:0]
	{
		IDLE,
		STEP,
		FINISH
	} step_state_e;

endpackage

// ==== include/plane_consts.svh ====
// plane-mode constants for luma 16x16 and chroma 8x8; widths sized for 8-bit pels only
`ifndef PLANE_CONSTS_SVH
`define PLANE_CONSTS_SVH

// --------------------------------------------------
// pel and line geometry
// --------------------------------------------------
`define PLANE_PEL_W        8
`define PLANE_LUMA_N       16
`define PLANE_CHROMA_N     8

// gradient steps per line, K = N/2
`define PLANE_LUMA_STEPS   8
`define PLANE_CHROMA_STEPS 4

// --------------------------------------------------
// b and c scaling
// --------------------------------------------------
`define PLANE_LUMA_MUL     5
`define PLANE_CHROMA_MUL   34
`define PLANE_ROUND        32
`define PLANE_SHIFT        6

// a = 16 * (sum of far-end pels)
`define PLANE_A_SHIFT      4

// --------------------------------------------------
// result widths
// --------------------------------------------------
`define PLANE_GRAD_W       15
`define PLANE_BC_W         12
`define PLANE_A_W          14
`define PLANE_SEED_W       16
`define PLANE_STEP_W       3

`endif
